//--- hdl/core_cfg_pkg.sv
package core_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath widths
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] xlen_t;

    localparam int REG_ADDR_W = 5;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // First fetch address out of reset
    localparam xlen_t RESET_PC = '0;

    //////////////////////////////////////////////////////////////////////
    // Execution unit controls
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // Which unit supplies the writeback value
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_LOAD,
        UNIT_LINK,
        UNIT_NONE
    } unit_sel_t;

endpackage

//--- hdl/riscv_isa_pkg.sv
package riscv_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    // Word width for LW and SW
    localparam logic [2:0] F3_WORD    = 3'b010;

    // funct7 that turns ADD into SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats, most significant field first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_type_t;

    // One fetched word, read through whichever format the opcode calls for
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        j_type_t j;
    } instr_u;

endpackage

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_req,
    input  logic                redirect,
    input  core_cfg_pkg::xlen_t target,
    output core_cfg_pkg::xlen_t pc,
    output logic                instr_en,
    output core_cfg_pkg::xlen_t instr_addr
);

    // Set while the fetched word is being executed
    logic in_execute;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= core_cfg_pkg::RESET_PC;
            in_execute <= 1'b0;
        end else begin
            in_execute <= fetch_req;
            // PC moves on as the instruction leaves EXECUTE
            if (in_execute) begin
                pc <= redirect ? target : pc + 32'd4;
            end
        end
    end

    assign instr_en   = fetch_req;
    assign instr_addr = pc;

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                    clk,
    input  core_cfg_pkg::reg_addr_t rs1_addr,
    input  core_cfg_pkg::reg_addr_t rs2_addr,
    output core_cfg_pkg::xlen_t     rs1_data,
    output core_cfg_pkg::xlen_t     rs2_data,
    input  core_cfg_pkg::reg_addr_t rd_addr,
    input  logic                    rd_we,
    input  core_cfg_pkg::xlen_t     rd_data
);

    // x1 to x31, x0 has no storage
    core_cfg_pkg::xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Asynchronous reads
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  core_cfg_pkg::alu_op_t alu_op,
    input  core_cfg_pkg::xlen_t   rs1_data,
    input  core_cfg_pkg::xlen_t   rs2_data,
    input  logic                  use_imm,
    input  core_cfg_pkg::xlen_t   imm,
    output core_cfg_pkg::xlen_t   alu_result
);

    core_cfg_pkg::xlen_t operand_b;
    logic                less_than;

    // ADDI takes the immediate in place of rs2
    assign operand_b = use_imm ? imm : rs2_data;

    assign less_than = $signed(rs1_data) < $signed(operand_b);

    always_comb begin
        case (alu_op)
            core_cfg_pkg::ALU_ADD: alu_result = rs1_data + operand_b;
            core_cfg_pkg::ALU_SUB: alu_result = rs1_data - operand_b;
            core_cfg_pkg::ALU_AND: alu_result = rs1_data & operand_b;
            core_cfg_pkg::ALU_OR:  alu_result = rs1_data | operand_b;
            core_cfg_pkg::ALU_XOR: alu_result = rs1_data ^ operand_b;
            core_cfg_pkg::ALU_SLT:
                alu_result = {{(core_cfg_pkg::XLEN-1){1'b0}}, less_than};
            default:               alu_result = '0;
        endcase
    end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  riscv_isa_pkg::instr_u instr,
    input  core_cfg_pkg::xlen_t   pc,
    input  core_cfg_pkg::xlen_t   rs1_data,
    input  core_cfg_pkg::xlen_t   rs2_data,
    input  core_cfg_pkg::xlen_t   imm,
    input  logic                  is_jump,
    output logic                  branch_taken,
    output core_cfg_pkg::xlen_t   target,
    output core_cfg_pkg::xlen_t   link_value
);

    logic equal;
    logic cond_met;

    assign equal = (rs1_data == rs2_data);

    // Only BEQ and BNE, other compares never take
    always_comb begin
        case (instr.b.funct3)
            riscv_isa_pkg::F3_BEQ: cond_met = equal;
            riscv_isa_pkg::F3_BNE: cond_met = !equal;
            default:               cond_met = 1'b0;
        endcase
    end

    assign branch_taken = is_jump | cond_met;
    assign target       = pc + imm;
    assign link_value   = pc + 32'd4;

endmodule

//--- hdl/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_req,
    input  logic                mem_write,
    input  core_cfg_pkg::xlen_t rs1_data,
    input  core_cfg_pkg::xlen_t rs2_data,
    input  core_cfg_pkg::xlen_t imm,
    output logic                data_en,
    output logic                data_we,
    output core_cfg_pkg::xlen_t data_addr,
    output core_cfg_pkg::xlen_t data_wdata,
    input  core_cfg_pkg::xlen_t data_rdata,
    output core_cfg_pkg::xlen_t load_data
);

    core_cfg_pkg::xlen_t eff_addr;
    core_cfg_pkg::xlen_t load_hold;
    logic                read_pending;

    // Low address bits dropped for word access
    assign eff_addr   = rs1_data + imm;
    assign data_addr  = {eff_addr[31:2], 2'b00};
    assign data_en    = mem_req;
    assign data_we    = mem_write;
    assign data_wdata = rs2_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_pending <= 1'b0;
        end else begin
            read_pending <= mem_req & ~mem_write;
        end
    end

    // Capture the returned word so it stays put after LOAD_WAIT
    always_ff @(posedge clk) begin
        if (read_pending) begin
            load_hold <= data_rdata;
        end
    end

    assign load_data = read_pending ? data_rdata : load_hold;

endmodule

//--- hdl/decode_and_issue.sv
`timescale 1ns/1ps

module decode_and_issue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  riscv_isa_pkg::instr_u     instr,
    input  core_cfg_pkg::xlen_t       alu_result,
    input  core_cfg_pkg::xlen_t       link_value,
    input  core_cfg_pkg::xlen_t       load_data,
    input  logic                      branch_taken,
    output logic                      fetch_req,
    output logic                      redirect,
    output logic                      mem_req,
    output logic                      mem_write,
    output core_cfg_pkg::reg_addr_t   rs1_addr,
    output core_cfg_pkg::reg_addr_t   rs2_addr,
    output core_cfg_pkg::reg_addr_t   rd_addr,
    output logic                      rd_we,
    output core_cfg_pkg::xlen_t       rd_data,
    output core_cfg_pkg::alu_op_t     alu_op,
    output logic                      use_imm,
    output core_cfg_pkg::xlen_t       imm,
    output logic                      is_jump
);

    typedef enum logic [1:0] {S_FETCH, S_EXECUTE, S_LOAD_WAIT} state_t;

    state_t                  state;
    state_t                  next_state;
    core_cfg_pkg::reg_addr_t load_rd;
    core_cfg_pkg::unit_sel_t unit_sel;
    core_cfg_pkg::unit_sel_t wb_sel;
    logic                    is_load;
    logic                    is_store;
    logic                    is_branch;
    logic                    in_exec;

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    // Reset returns to FETCH so the first fetch follows reset release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_FETCH;
            load_rd <= '0;
        end else begin
            state <= next_state;
            if (in_exec) begin
                load_rd <= instr.r.rd;
            end
        end
    end

    always_comb begin
        case (state)
            S_FETCH:   next_state = S_EXECUTE;
            S_EXECUTE: next_state = is_load ? S_LOAD_WAIT : S_FETCH;
            default:   next_state = S_FETCH;
        endcase
    end

    assign in_exec   = (state == S_EXECUTE);
    // No fetch request while reset is held
    assign fetch_req = rst_n && (state == S_FETCH);

    //////////////////////////////////////////////////////////////////////
    // Instruction decode
    always_comb begin
        imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
        use_imm   = 1'b0;
        alu_op    = core_cfg_pkg::ALU_ADD;
        unit_sel  = core_cfg_pkg::UNIT_NONE;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (instr.r.opcode)
            riscv_isa_pkg::OPC_OP: begin
                unit_sel = core_cfg_pkg::UNIT_ALU;
                case (instr.r.funct3)
                    riscv_isa_pkg::F3_ADD_SUB:
                        alu_op = (instr.r.funct7 == riscv_isa_pkg::F7_SUB) ?
                                 core_cfg_pkg::ALU_SUB : core_cfg_pkg::ALU_ADD;
                    riscv_isa_pkg::F3_SLT: alu_op = core_cfg_pkg::ALU_SLT;
                    riscv_isa_pkg::F3_XOR: alu_op = core_cfg_pkg::ALU_XOR;
                    riscv_isa_pkg::F3_OR:  alu_op = core_cfg_pkg::ALU_OR;
                    riscv_isa_pkg::F3_AND: alu_op = core_cfg_pkg::ALU_AND;
                    // Shifts and SLTU retire as no-ops
                    default: unit_sel = core_cfg_pkg::UNIT_NONE;
                endcase
            end
            riscv_isa_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                if (instr.i.funct3 == riscv_isa_pkg::F3_ADD_SUB) begin
                    unit_sel = core_cfg_pkg::UNIT_ALU;
                end
            end
            riscv_isa_pkg::OPC_LOAD: begin
                is_load = (instr.i.funct3 == riscv_isa_pkg::F3_WORD);
            end
            riscv_isa_pkg::OPC_STORE: begin
                imm      = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
                is_store = (instr.s.funct3 == riscv_isa_pkg::F3_WORD);
            end
            riscv_isa_pkg::OPC_BRANCH: begin
                imm       = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                             instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
                is_branch = 1'b1;
            end
            riscv_isa_pkg::OPC_JAL: begin
                imm      = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                            instr.j.imm_11, instr.j.imm_10_1, 1'b0};
                unit_sel = core_cfg_pkg::UNIT_LINK;
                is_jump  = 1'b1;
            end
            default: ;
        endcase
    end

    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;

    // Memory and control flow requests only in EXECUTE
    assign mem_req   = in_exec & (is_load | is_store);
    assign mem_write = in_exec & is_store;
    assign redirect  = in_exec & (is_jump | (is_branch & branch_taken));

    //////////////////////////////////////////////////////////////////////
    // Writeback
    assign wb_sel  = (state == S_LOAD_WAIT) ? core_cfg_pkg::UNIT_LOAD : unit_sel;
    assign rd_addr = (state == S_LOAD_WAIT) ? load_rd : instr.r.rd;

    always_comb begin
        case (wb_sel)
            core_cfg_pkg::UNIT_ALU:  rd_data = alu_result;
            core_cfg_pkg::UNIT_LOAD: rd_data = load_data;
            core_cfg_pkg::UNIT_LINK: rd_data = link_value;
            default:                 rd_data = '0;
        endcase
    end

    // x0 is never written
    assign rd_we = ((in_exec && (unit_sel == core_cfg_pkg::UNIT_ALU ||
                                 unit_sel == core_cfg_pkg::UNIT_LINK)) ||
                    state == S_LOAD_WAIT) && (rd_addr != '0);

endmodule

//--- hdl/rv32_core.sv
`timescale 1ns/1ps

module rv32_core (
    input  logic                clk,
    input  logic                rst_n,
    output logic                instr_en,
    output core_cfg_pkg::xlen_t instr_addr,
    input  core_cfg_pkg::xlen_t instr_data,
    output logic                data_en,
    output logic                data_we,
    output core_cfg_pkg::xlen_t data_addr,
    output core_cfg_pkg::xlen_t data_wdata,
    input  core_cfg_pkg::xlen_t data_rdata
);

    //////////////////////////////////////////////////////////////////////
    // Connecting signals
    logic                    fetch_req;
    logic                    redirect;
    logic                    mem_req;
    logic                    mem_write;
    core_cfg_pkg::reg_addr_t rs1_addr;
    core_cfg_pkg::reg_addr_t rs2_addr;
    core_cfg_pkg::reg_addr_t rd_addr;
    logic                    rd_we;
    core_cfg_pkg::xlen_t     rd_data;
    core_cfg_pkg::xlen_t     rs1_data;
    core_cfg_pkg::xlen_t     rs2_data;
    core_cfg_pkg::alu_op_t   alu_op;
    logic                    use_imm;
    core_cfg_pkg::xlen_t     imm;
    logic                    is_jump;
    core_cfg_pkg::xlen_t     alu_result;
    core_cfg_pkg::xlen_t     link_value;
    core_cfg_pkg::xlen_t     load_data;
    logic                    branch_taken;
    core_cfg_pkg::xlen_t     target;
    core_cfg_pkg::xlen_t     pc;

    //////////////////////////////////////////////////////////////////////
    // Decode and issue
    decode_and_issue decode_and_issue_block (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr_data),
        .alu_result   (alu_result),
        .link_value   (link_value),
        .load_data    (load_data),
        .branch_taken (branch_taken),
        .fetch_req    (fetch_req),
        .redirect     (redirect),
        .mem_req      (mem_req),
        .mem_write    (mem_write),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .rd_we        (rd_we),
        .rd_data      (rd_data),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .imm          (imm),
        .is_jump      (is_jump)
    );

    fetch_unit fetch_block (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .redirect   (redirect),
        .target     (target),
        .pc         (pc),
        .instr_en   (instr_en),
        .instr_addr (instr_addr)
    );

    register_file register_file_block (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_addr  (rd_addr),
        .rd_we    (rd_we),
        .rd_data  (rd_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_block (
        .alu_op     (alu_op),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .use_imm    (use_imm),
        .imm        (imm),
        .alu_result (alu_result)
    );

    branch_unit branch_unit_block (
        .instr        (instr_data),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .is_jump      (is_jump),
        .branch_taken (branch_taken),
        .target       (target),
        .link_value   (link_value)
    );

    load_store_unit load_store_unit_block (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_req    (mem_req),
        .mem_write  (mem_write),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .data_en    (data_en),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .load_data  (load_data)
    );

endmodule

//--- testbench/rv32_core_chk.sv
`timescale 1ns/1ps

module rv32_core_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                instr_en,
    input core_cfg_pkg::xlen_t instr_addr,
    input logic                data_en,
    input logic                data_we
);

    // Core state is known once one reset edge has passed
    logic reset_seen = 1'b0;
    logic reset_held = 1'b0;
    int   fail_count = 0;

    always @(posedge clk) begin
        reset_held <= !rst_n;
        if (!rst_n) begin
            reset_seen <= 1'b1;
        end
    end

    we_needs_en: assert property (@(posedge clk) disable iff (!reset_seen)
        data_we |-> data_en)
        else begin
            $error("data_we high without data_en");
            fail_count++;
        end

    one_port_at_a_time: assert property (@(posedge clk) disable iff (!reset_seen)
        !(instr_en && data_en))
        else begin
            $error("instr_en and data_en high together");
            fail_count++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!reset_seen)
        instr_en |-> (instr_addr[1:0] == 2'b00))
        else begin
            $error("instruction fetch address not word aligned");
            fail_count++;
        end

    // One cycle into reset both ports must be idle
    quiet_in_reset: assert property (@(posedge clk) disable iff (!reset_seen)
        (!rst_n && reset_held) |-> (!instr_en && !data_en))
        else begin
            $error("memory request while reset held");
            fail_count++;
        end

endmodule

bind rv32_core rv32_core_chk rv32_core_chk_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_en   (instr_en),
    .instr_addr (instr_addr),
    .data_en    (data_en),
    .data_we    (data_we)
);

//--- testbench/rv32_core_tb.sv
`timescale 1ns/1ps

module rv32_core_tb;

    localparam int RESET_CYCLES = 8;
    localparam int MEM_WORDS    = 64;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                instr_en;
    core_cfg_pkg::xlen_t instr_addr;
    core_cfg_pkg::xlen_t instr_data = '0;
    logic                data_en;
    logic                data_we;
    core_cfg_pkg::xlen_t data_addr;
    core_cfg_pkg::xlen_t data_wdata;
    core_cfg_pkg::xlen_t data_rdata = '0;

    // The data side reloads from data_image during reset
    core_cfg_pkg::xlen_t imem [MEM_WORDS];
    core_cfg_pkg::xlen_t dmem [MEM_WORDS];
    core_cfg_pkg::xlen_t data_image [MEM_WORDS];

    core_cfg_pkg::xlen_t prog [$];
    core_cfg_pkg::xlen_t fetch_log [$];
    core_cfg_pkg::xlen_t store_addr_log [$];
    core_cfg_pkg::xlen_t store_data_log [$];
    int                  cycle_count = 0;
    int                  cycle_limit = 50;

    always #20 clk = ~clk;

    rv32_core rv32_core_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_en   (instr_en),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_en    (data_en),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory models with one cycle read latency on both ports
    always @(posedge clk) begin
        if (instr_en) begin
            instr_data <= imem[instr_addr[7:2]];
        end
        if (!rst_n) begin
            dmem <= data_image;
        end else if (data_en && data_we) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end else if (data_en) begin
            data_rdata <= dmem[data_addr[7:2]];
        end
    end

    // Fetch and store logs
    always @(posedge clk) begin
        if (rst_n && instr_en) begin
            fetch_log.push_back(instr_addr);
        end
        if (rst_n && data_en && data_we) begin
            store_addr_log.push_back(data_addr);
            store_data_log.push_back(data_wdata);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "Run stopped at the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // RV32I instruction encoders
    function automatic core_cfg_pkg::xlen_t r_instr(input logic [6:0] f7, input logic [2:0] f3,
                                                   input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), riscv_isa_pkg::OPC_OP};
    endfunction

    function automatic core_cfg_pkg::xlen_t addi_instr(input int rd, input int rs1,
                                                      input logic [11:0] imm);
        return {imm, 5'(rs1), 3'b000, 5'(rd), riscv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic core_cfg_pkg::xlen_t lw_instr(input int rd, input int rs1,
                                                    input logic [11:0] imm);
        return {imm, 5'(rs1), 3'b010, 5'(rd), riscv_isa_pkg::OPC_LOAD};
    endfunction

    function automatic core_cfg_pkg::xlen_t sw_instr(input int rs2, input int rs1,
                                                    input logic [11:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], riscv_isa_pkg::OPC_STORE};
    endfunction

    function automatic core_cfg_pkg::xlen_t branch_instr(input logic [2:0] f3, input int rs1,
                                                        input int rs2, input logic [12:0] off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11],
                riscv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic core_cfg_pkg::xlen_t jal_instr(input int rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), riscv_isa_pkg::OPC_JAL};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_word(input core_cfg_pkg::xlen_t expected,
                              input core_cfg_pkg::xlen_t actual, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %08h, got %08h",
                     $time, what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Word compare failed");
        end
    endtask

    task automatic check_pc(input core_cfg_pkg::xlen_t expected,
                            input core_cfg_pkg::xlen_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: fetch address expected %08h, got %08h",
                     $time, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Fetch address compare failed");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequencing helpers
    // Loads prog ahead of a halt loop and runs the core out of reset
    task automatic start_program();
        prog.push_back(jal_instr(0, 21'd0));
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        // Unused words hold an unknown opcode tagged with their index
        foreach (imem[i]) begin
            imem[i] = {25'(i), 7'b0000000};
        end
        foreach (prog[i]) begin
            imem[i] = prog[i];
        end
        fetch_log.delete();
        store_addr_log.delete();
        store_data_log.delete();
        cycle_limit = cycle_limit + 3 * prog.size() + RESET_CYCLES + 4;
        repeat (RESET_CYCLES - 2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_stores(input int count);
        while (store_data_log.size() < count) begin
            @(posedge clk);
        end
    endtask

    task automatic expect_store(input core_cfg_pkg::xlen_t addr,
                                input core_cfg_pkg::xlen_t value);
        check_word(addr, store_addr_log.pop_front(), "store address");
        check_word(value, store_data_log.pop_front(), "store data");
    endtask

    task automatic expect_fetches(input core_cfg_pkg::xlen_t expected [$]);
        if (fetch_log.size() < expected.size()) begin
            $display("Too few instruction fetches: saw %0d, wanted %0d",
                     fetch_log.size(), expected.size());
            $display("TESTBENCH FAILED");
            $fatal(1, "Fetch sequence too short");
        end
        foreach (expected[i]) begin
            check_pc(expected[i], fetch_log[i]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    task automatic straight_line_fetch();
        prog = '{addi_instr(1, 0, 12'd1), addi_instr(2, 0, 12'd2),
                 addi_instr(3, 1, 12'd5), sw_instr(3, 0, 12'h010)};
        start_program();
        wait_stores(1);
        expect_fetches('{core_cfg_pkg::RESET_PC, core_cfg_pkg::RESET_PC + 32'd4,
                         core_cfg_pkg::RESET_PC + 32'd8, core_cfg_pkg::RESET_PC + 32'd12});
        expect_store(32'h10, 32'd6);
    endtask

    task automatic alu_ops_to_memory();
        core_cfg_pkg::xlen_t a;
        core_cfg_pkg::xlen_t b;
        a = 32'd1234;
        b = 32'hFFFF_FFF9;
        // funct7 0100000 selects SUB and funct3 picks the operation
        prog = '{addi_instr(1, 0, a[11:0]), addi_instr(2, 0, b[11:0]),
                 r_instr(7'h00, 3'b000, 3, 1, 2), sw_instr(3, 0, 12'd0),
                 r_instr(7'h20, 3'b000, 3, 1, 2), sw_instr(3, 0, 12'd4),
                 r_instr(7'h00, 3'b111, 3, 1, 2), sw_instr(3, 0, 12'd8),
                 r_instr(7'h00, 3'b110, 3, 1, 2), sw_instr(3, 0, 12'd12),
                 r_instr(7'h00, 3'b100, 3, 1, 2), sw_instr(3, 0, 12'd16),
                 r_instr(7'h00, 3'b010, 3, 2, 1), sw_instr(3, 0, 12'd20),
                 r_instr(7'h00, 3'b010, 3, 1, 2), sw_instr(3, 0, 12'd24),
                 sw_instr(1, 0, 12'd28)};
        start_program();
        wait_stores(8);
        expect_store(32'd0, a + b);
        expect_store(32'd4, a - b);
        expect_store(32'd8, a & b);
        expect_store(32'd12, a | b);
        expect_store(32'd16, a ^ b);
        expect_store(32'd20, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expect_store(32'd24, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expect_store(32'd28, a);
    endtask

    task automatic load_add_store();
        data_image[16] = 32'h1357_9BDF;
        prog = '{addi_instr(5, 0, 12'h030), lw_instr(6, 5, 12'd16),
                 addi_instr(7, 0, 12'd25), r_instr(7'h00, 3'b000, 8, 6, 7),
                 sw_instr(8, 5, 12'd8)};
        start_program();
        wait_stores(1);
        expect_store(32'h30 + 32'd8, 32'h1357_9BDF + 32'd25);
    endtask

    task automatic follow_branches();
        prog = '{addi_instr(1, 0, 12'd5), addi_instr(2, 0, 12'd5),
                 branch_instr(3'b000, 1, 2, 13'd8), addi_instr(3, 0, 12'd1),
                 branch_instr(3'b001, 1, 2, 13'd8), addi_instr(4, 0, 12'd9),
                 addi_instr(2, 0, 12'd6), branch_instr(3'b000, 1, 2, 13'd8),
                 branch_instr(3'b001, 1, 2, 13'd8), addi_instr(4, 0, 12'd77),
                 sw_instr(4, 0, 12'd0)};
        start_program();
        wait_stores(1);
        // Taken BEQ skips 12 and taken BNE skips 36
        expect_fetches('{32'd0, 32'd4, 32'd8, 32'd16, 32'd20, 32'd24, 32'd28,
                         32'd32, 32'd40});
        expect_store(32'd0, 32'd9);
    endtask

    task automatic jal_link_and_x0();
        prog = '{addi_instr(1, 0, 12'd3), jal_instr(5, 21'd8),
                 addi_instr(1, 0, 12'd99), sw_instr(5, 0, 12'd0),
                 addi_instr(0, 0, 12'd123), sw_instr(0, 0, 12'd4),
                 sw_instr(1, 0, 12'd8)};
        start_program();
        wait_stores(3);
        expect_fetches('{32'd0, 32'd4, 32'd12, 32'd16, 32'd20, 32'd24});
        // Link value is the JAL address plus four
        expect_store(32'd0, 32'd4 + 32'd4);
        expect_store(32'd4, 32'd0);
        expect_store(32'd8, 32'd3);
    endtask

    task automatic random_addi_chain();
        logic [11:0]         imm;
        core_cfg_pkg::xlen_t sum;
        prog.delete();
        sum = '0;
        for (int k = 0; k < 8; k++) begin
            imm = 12'($urandom);
            sum = sum + {{20{imm[11]}}, imm};
            prog.push_back(addi_instr(10, (k == 0) ? 0 : 10, imm));
        end
        prog.push_back(sw_instr(10, 0, 12'h020));
        start_program();
        wait_stores(1);
        expect_store(32'h20, sum);
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(5));
        foreach (data_image[i]) begin
            data_image[i] = 32'hD00D_0000 ^ 32'(i << 2);
        end
        straight_line_fetch();
        alu_ops_to_memory();
        load_add_store();
        follow_branches();
        jal_link_and_x0();
        random_addi_chain();
        if (rv32_core_inst.rv32_core_chk_inst.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("Port assertions failed %0d times",
                     rv32_core_inst.rv32_core_chk_inst.fail_count);
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
hdl/core_cfg_pkg.sv
hdl/riscv_isa_pkg.sv
hdl/fetch_unit.sv
hdl/register_file.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/load_store_unit.sv
hdl/decode_and_issue.sv
hdl/rv32_core.sv
testbench/rv32_core_chk.sv
testbench/rv32_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= rv32_core_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
